// ==== Makefile ====
# Verilator build and run for the inbound return queue testbench

TOP = tb_inq_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+include
logic/inq_pkg.sv
logic/inq_rf_if.sv
logic/rf_32x108.sv
logic/inq_ctl.sv
logic/inq_top.sv
tb/tb_inq_top.sv

// ==== logic/inq_ctl.sv ====
////////////////////////////////////////
// inq_ctl
// queue pointers and occupancy, request
// arbitration, register file address
// generation and read valid pipeline
////////////////////////////////////////

`timescale 1ns/10ps

module inq_ctl (
   input  logic                       rclk,
   input  logic                       reset_l,
   // producer side
   input  logic                       push,
   input  logic [inq_pkg::DATA_W-1:0] push_data,
   input  logic                       upd,
   input  logic [inq_pkg::ADR_W-1:0]  upd_idx,
   input  logic [inq_pkg::LANES-1:0]  upd_word_wen,
   input  logic [inq_pkg::DATA_W-1:0] upd_data,
   // consumer side
   input  logic                       pop,
   input  logic                       peek,
   input  logic [inq_pkg::ADR_W-1:0]  peek_idx,
   output logic                       rdata_vld,
   // status
   output logic                       full,
   output logic                       empty,
   output logic [inq_pkg::CNT_W-1:0]  count,
   // register file ports
   inq_rf_if.ctl                      rf
);

   inq_pkg::wr_op_e wr_op;
   inq_pkg::rd_op_e rd_op;

   logic [inq_pkg::ADR_W-1:0] head;
   logic [inq_pkg::ADR_W-1:0] tail;
   logic [inq_pkg::CNT_W-1:0] cnt;

   logic [inq_pkg::ADR_W-1:0] upd_adr;
   logic [inq_pkg::ADR_W-1:0] peek_adr;
   logic                      upd_ok;
   logic                      peek_ok;

   // read valid stages behind the registered read enable
   logic                      vld_p1;
   logic                      vld_p2;

   ////////////////////////////////////////
   // status and offsets
   ////////////////////////////////////////

   assign full  = (cnt == inq_pkg::CNT_W'(inq_pkg::DEPTH));
   assign empty = (cnt == '0);
   assign count = cnt;

   // offsets from the head wrap modulo 32 on their own
   assign upd_adr  = head + upd_idx;
   assign peek_adr = head + peek_idx;

   // offset must point inside the queued entries
   assign upd_ok  = ({1'b0, upd_idx} < cnt);
   assign peek_ok = ({1'b0, peek_idx} < cnt);

   ////////////////////////////////////////
   // arbitration
   ////////////////////////////////////////

   // a push strobe always shadows an update, even one that
   // is then dropped because the queue is full
   always_comb begin
      wr_op = inq_pkg::WR_NONE;
      if (push) begin
         if (!full) begin
            wr_op = inq_pkg::WR_PUSH;
         end
      end else if (upd && upd_ok) begin
         wr_op = inq_pkg::WR_UPD;
      end
   end

   // same for pop over peek
   always_comb begin
      rd_op = inq_pkg::RD_NONE;
      if (pop) begin
         if (!empty) begin
            rd_op = inq_pkg::RD_POP;
         end
      end else if (peek && peek_ok) begin
         rd_op = inq_pkg::RD_PEEK;
      end
   end

   ////////////////////////////////////////
   // pointers and occupancy
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset_l) begin
         head <= '0;
         tail <= '0;
         cnt  <= '0;
      end else begin
         if (wr_op == inq_pkg::WR_PUSH) begin
            tail <= tail + 1'b1;
         end
         if (rd_op == inq_pkg::RD_POP) begin
            head <= head + 1'b1;
         end
         // push and pop together leave the count alone
         case ({wr_op == inq_pkg::WR_PUSH, rd_op == inq_pkg::RD_POP})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   ////////////////////////////////////////
   // register file request stage
   ////////////////////////////////////////

   // enables and the valid pipe
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         rf.wr_en   <= 1'b0;
         rf.read_en <= 1'b0;
         vld_p1     <= 1'b0;
         vld_p2     <= 1'b0;
      end else begin
         rf.wr_en   <= (wr_op != inq_pkg::WR_NONE);
         rf.read_en <= (rd_op != inq_pkg::RD_NONE);
         vld_p1     <= rf.read_en;
         vld_p2     <= vld_p1;
      end
   end

   // addresses, lanes and data, only meaningful with an enable
   always_ff @(posedge rclk) begin
      rf.wr_adr      <= (wr_op == inq_pkg::WR_PUSH) ? tail : upd_adr;
      rf.word_wen    <= (wr_op == inq_pkg::WR_PUSH) ? '1 : upd_word_wen;
      rf.din         <= push ? push_data : upd_data;
      rf.rd_adr1     <= head;
      rf.rd_adr2     <= peek_adr;
      rf.sel_rdaddr1 <= (rd_op == inq_pkg::RD_POP);
   end

   // lines up with dout loading in the array
   assign rdata_vld = vld_p2;

endmodule

// ==== logic/inq_pkg.sv ====
////////////////////////////////////////
// inq_pkg
// sizes of the inbound return queue and
// the encodings of accepted requests
////////////////////////////////////////

package inq_pkg;

   ////////////////////////////////////////
   // queue geometry
   ////////////////////////////////////////

   // entry width in bits
   localparam int DATA_W = 108;
   // number of queue entries
   localparam int DEPTH  = 32;
   // entry address width
   localparam int ADR_W  = 5;
   // occupancy needs one bit more than the address to hold 32
   localparam int CNT_W  = 6;
   // interleaved word lanes, bit i belongs to lane i mod 4
   localparam int LANES  = 4;

   ////////////////////////////////////////
   // request kinds
   ////////////////////////////////////////

   // write taken in a cycle
   typedef enum logic [1:0] {
      WR_NONE = 2'd0,
      WR_PUSH = 2'd1,
      WR_UPD  = 2'd2
   } wr_op_e;

   // read taken in a cycle
   typedef enum logic [1:0] {
      RD_NONE = 2'd0,
      RD_POP  = 2'd1,
      RD_PEEK = 2'd2
   } rd_op_e;

endpackage

// ==== logic/inq_rf_if.sv ====
////////////////////////////////////////
// inq_rf_if
// port signals of the queue register
// file, from controller to array
////////////////////////////////////////

`timescale 1ns/10ps

interface inq_rf_if;

   // write side
   logic [inq_pkg::DATA_W-1:0] din;
   logic [inq_pkg::ADR_W-1:0]  wr_adr;
   logic                       wr_en;
   logic [inq_pkg::LANES-1:0]  word_wen;

   // read side, two address sources
   logic [inq_pkg::ADR_W-1:0]  rd_adr1;
   logic [inq_pkg::ADR_W-1:0]  rd_adr2;
   logic                       sel_rdaddr1;
   logic                       read_en;

   modport ctl (
      output din, wr_adr, wr_en, word_wen,
      output rd_adr1, rd_adr2, sel_rdaddr1, read_en
   );

   modport rf (
      input din, wr_adr, wr_en, word_wen,
      input rd_adr1, rd_adr2, sel_rdaddr1, read_en
   );

endinterface

// ==== logic/inq_top.sv ====
////////////////////////////////////////
// inq_top
// inbound return queue, 32 entries of
// 108 bits with push, lane update, pop
// and peek
////////////////////////////////////////

`timescale 1ns/10ps

module inq_top (
   input  logic                       rclk,
   input  logic                       reset_l,
   // push at the tail
   input  logic                       push,
   input  logic [inq_pkg::DATA_W-1:0] push_data,
   // lane update relative to the head
   input  logic                       upd,
   input  logic [inq_pkg::ADR_W-1:0]  upd_idx,
   input  logic [inq_pkg::LANES-1:0]  upd_word_wen,
   input  logic [inq_pkg::DATA_W-1:0] upd_data,
   // pop or peek
   input  logic                       pop,
   input  logic                       peek,
   input  logic [inq_pkg::ADR_W-1:0]  peek_idx,
   // read return
   output logic [inq_pkg::DATA_W-1:0] rdata,
   output logic                       rdata_vld,
   // status
   output logic                       full,
   output logic                       empty,
   output logic [inq_pkg::CNT_W-1:0]  count
);

   ////////////////////////////////////////
   // controller to array bus
   ////////////////////////////////////////

   inq_rf_if rf_bus ();

   inq_ctl u_ctl (
      .rclk         (rclk),
      .reset_l      (reset_l),
      .push         (push),
      .push_data    (push_data),
      .upd          (upd),
      .upd_idx      (upd_idx),
      .upd_word_wen (upd_word_wen),
      .upd_data     (upd_data),
      .pop          (pop),
      .peek         (peek),
      .peek_idx     (peek_idx),
      .rdata_vld    (rdata_vld),
      .full         (full),
      .empty        (empty),
      .count        (count),
      .rf           (rf_bus.ctl)
   );

   // array output is the read return directly
   rf_32x108 u_rf (
      .rclk    (rclk),
      .reset_l (reset_l),
      .rf      (rf_bus.rf),
      .dout    (rdata)
   );

endmodule

// ==== logic/rf_32x108.sv ====
////////////////////////////////////////
// rf_32x108
// 32 x 108 register file, one read and
// one write port, input registers and
// four interleaved word-lane enables
////////////////////////////////////////

`timescale 1ns/10ps

module rf_32x108 (
   input  logic                       rclk,
   input  logic                       reset_l,
   inq_rf_if.rf                       rf,
   output logic [inq_pkg::DATA_W-1:0] dout
);

   ////////////////////////////////////////
   // storage and input stage
   ////////////////////////////////////////

   logic [inq_pkg::DATA_W-1:0] inq_ary [inq_pkg::DEPTH];

   logic [inq_pkg::DATA_W-1:0] wrdata_d1;
   logic [inq_pkg::LANES-1:0]  word_wen_d1;
   logic [inq_pkg::ADR_W-1:0]  wrptr_d1;
   logic [inq_pkg::ADR_W-1:0]  rdptr_d1;
   logic                       wr_en_d1;
   logic                       ren_d1;

   // per-bit write mask built from the lane enables
   logic [inq_pkg::DATA_W-1:0] bit_en_d1;
   // entry contents after the lane merge
   logic [inq_pkg::DATA_W-1:0] merge_data;

   // enables are cleared so nothing fires out of reset
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         wr_en_d1 <= 1'b0;
         ren_d1   <= 1'b0;
      end else begin
         wr_en_d1 <= rf.wr_en;
         ren_d1   <= rf.read_en;
      end
   end

   // address, lane and data capture
   always_ff @(posedge rclk) begin
      wrdata_d1   <= rf.din;
      word_wen_d1 <= rf.word_wen;
      wrptr_d1    <= rf.wr_adr;
      // pick the read address source before it is registered
      rdptr_d1    <= rf.sel_rdaddr1 ? rf.rd_adr1 : rf.rd_adr2;
   end

   ////////////////////////////////////////
   // write port
   ////////////////////////////////////////

   // lane pattern repeats every four bits, so bit i
   // follows word_wen_d1[i mod 4]
   assign bit_en_d1 = {(inq_pkg::DATA_W / inq_pkg::LANES){word_wen_d1}};

   // untouched lanes keep their stored value
   assign merge_data = (inq_ary[wrptr_d1] & ~bit_en_d1) |
                       (wrdata_d1 & bit_en_d1);

   always_ff @(posedge rclk) begin
      if (wr_en_d1) begin
         inq_ary[wrptr_d1] <= merge_data;
      end
   end

   ////////////////////////////////////////
   // read port
   ////////////////////////////////////////

   // read and write on the same edge to the same entry
   // returns the contents from before the write
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         dout <= '0;
      end else if (ren_d1) begin
         dout <= inq_ary[rdptr_d1];
      end
   end

endmodule

// ==== include/inq_tb_model.svh ====
////////////////////////////////////////
// queue reference model
// shadow contents, pointers and the
// reads still owed by the DUT
////////////////////////////////////////

`ifndef INQ_TB_MODEL_SVH
`define INQ_TB_MODEL_SVH

logic [inq_pkg::DATA_W-1:0] m_ary [inq_pkg::DEPTH];
logic [inq_pkg::ADR_W-1:0]  m_head;
logic [inq_pkg::ADR_W-1:0]  m_tail;
int                         m_cnt;
// accepted reads, newest in bit 0, bit 2 means data due now
logic [2:0]                 m_rd_pipe;
logic [inq_pkg::DATA_W-1:0] m_rd_q [$];
// data expected on rdata while m_rd_pipe[2] is set
logic [inq_pkg::DATA_W-1:0] m_rd_exp;

function automatic void model_reset();
   m_head    = '0;
   m_tail    = '0;
   m_cnt     = 0;
   m_rd_pipe = '0;
   m_rd_exp  = '0;
   m_rd_q.delete();
endfunction

// bit i of the mask follows wen[i mod 4]
function automatic logic [inq_pkg::DATA_W-1:0] lane_mask(
   input logic [inq_pkg::LANES-1:0] wen
);
   logic [inq_pkg::DATA_W-1:0] mask;
   mask = '0;
   for (int n = 0; n < inq_pkg::DATA_W / inq_pkg::LANES; n++) begin
      mask = (mask << inq_pkg::LANES) | inq_pkg::DATA_W'(wen);
   end
   return mask;
endfunction

function automatic void model_step(
   input logic                       in_push,
   input logic [inq_pkg::DATA_W-1:0] in_pdata,
   input logic                       in_upd,
   input logic [inq_pkg::ADR_W-1:0]  in_uidx,
   input logic [inq_pkg::LANES-1:0]  in_uwen,
   input logic [inq_pkg::DATA_W-1:0] in_udata,
   input logic                       in_pop,
   input logic                       in_peek,
   input logic [inq_pkg::ADR_W-1:0]  in_pidx
);
   logic                       rd_take;
   logic [inq_pkg::DATA_W-1:0] rd_val;
   logic [inq_pkg::DATA_W-1:0] mask;
   logic [inq_pkg::ADR_W-1:0]  adr;
   logic                       pushed;
   logic                       popped;
   rd_take = 1'b0;
   rd_val  = '0;
   pushed  = 1'b0;
   popped  = 1'b0;
   // pop strobe wins, a peek beside it is dropped
   if (in_pop) begin
      if (m_cnt > 0) begin
         rd_take = 1'b1;
         rd_val  = m_ary[m_head];
         popped  = 1'b1;
      end
   end else if (in_peek && int'(in_pidx) < m_cnt) begin
      adr     = m_head + in_pidx;
      rd_take = 1'b1;
      rd_val  = m_ary[adr];
   end
   // read data was taken before this cycle's write lands
   if (in_push) begin
      if (m_cnt < inq_pkg::DEPTH) begin
         m_ary[m_tail] = in_pdata;
         m_tail        = m_tail + 1'b1;
         pushed        = 1'b1;
      end
   end else if (in_upd && int'(in_uidx) < m_cnt) begin
      adr        = m_head + in_uidx;
      mask       = lane_mask(in_uwen);
      m_ary[adr] = (m_ary[adr] & ~mask) | (in_udata & mask);
   end
   if (popped) begin
      m_head = m_head + 1'b1;
   end
   m_cnt = m_cnt + int'(pushed) - int'(popped);
   // read accepted two edges ago comes due
   if (m_rd_pipe[1]) begin
      m_rd_exp = m_rd_q.pop_front();
   end
   m_rd_pipe = {m_rd_pipe[1:0], rd_take};
   if (rd_take) begin
      m_rd_q.push_back(rd_val);
   end
endfunction

`endif

// ==== tb/tb_inq_top.sv ====
////////////////////////////////////////
// tb_inq_top
// testbench for the inbound return
// queue, model driven checks and report
////////////////////////////////////////

`timescale 1ns/10ps

module tb_inq_top;

   localparam int CLK_NS     = 8;
   localparam int RESET_CYC  = 5;
   localparam int N_ORDER    = 10;
   localparam int N_UPD_FILL = 16;
   localparam int N_UPD      = 40;
   localparam int N_PK_FILL  = 12;
   localparam int N_PEEK     = 20;
   // cycle budget of each test, reset first
   localparam int TEST_CYC = (RESET_CYC + 2) + 10 + (2 * N_ORDER + 6) +
                             (2 * inq_pkg::DEPTH + 8) + (2 * N_UPD_FILL + N_UPD + 8) +
                             (2 * N_PK_FILL + N_PEEK + 8) + 20;
   localparam int WATCHDOG_NS = TEST_CYC * CLK_NS + 800;

   logic                       rclk;
   logic                       reset_l;
   logic                       push;
   logic [inq_pkg::DATA_W-1:0] push_data;
   logic                       upd;
   logic [inq_pkg::ADR_W-1:0]  upd_idx;
   logic [inq_pkg::LANES-1:0]  upd_word_wen;
   logic [inq_pkg::DATA_W-1:0] upd_data;
   logic                       pop;
   logic                       peek;
   logic [inq_pkg::ADR_W-1:0]  peek_idx;
   logic [inq_pkg::DATA_W-1:0] rdata;
   logic                       rdata_vld;
   logic                       full;
   logic                       empty;
   logic [inq_pkg::CNT_W-1:0]  count;

   integer seed          = 32'h1f46;
   int     err_cnt       = 0;
   int     chk_cnt       = 0;
   int     test_cnt      = 0;
   int     test_err_base = 0;
   logic   in_reset      = 1'b1;

   `include "inq_tb_model.svh"

   inq_top i_inq_top (
      .rclk         (rclk),
      .reset_l      (reset_l),
      .push         (push),
      .push_data    (push_data),
      .upd          (upd),
      .upd_idx      (upd_idx),
      .upd_word_wen (upd_word_wen),
      .upd_data     (upd_data),
      .pop          (pop),
      .peek         (peek),
      .peek_idx     (peek_idx),
      .rdata        (rdata),
      .rdata_vld    (rdata_vld),
      .full         (full),
      .empty        (empty),
      .count        (count)
   );

   initial begin
      rclk = 1'b0;
      forever #(CLK_NS / 2) rclk = ~rclk;
   end

   ////////////////////////////////////////
   // model and checks
   ////////////////////////////////////////

   // model samples the same inputs as the DUT on the same edge
   always @(posedge rclk) begin
      if (reset_l) begin
         in_reset = 1'b1;
         model_reset();
      end else begin
         in_reset = 1'b0;
         model_step(push, push_data, upd, upd_idx, upd_word_wen, upd_data,
                    pop, peek, peek_idx);
      end
   end

   // outputs are all registered, so mid cycle they are settled
   always @(negedge rclk) begin
      if (!in_reset) begin
         chk_cnt = chk_cnt + 4;
         assert (int'(count) == m_cnt) else begin
            $display("CHECK FAILED count: got %h expected %h", count, m_cnt);
            err_cnt++;
         end
         assert (full === (m_cnt == inq_pkg::DEPTH)) else begin
            $display("CHECK FAILED full: got %h expected %h", full,
                     (m_cnt == inq_pkg::DEPTH));
            err_cnt++;
         end
         assert (empty === (m_cnt == 0)) else begin
            $display("CHECK FAILED empty: got %h expected %h", empty, (m_cnt == 0));
            err_cnt++;
         end
         // valid pulse exactly two edges after the accepting edge
         assert (rdata_vld === m_rd_pipe[2]) else begin
            $display("CHECK FAILED rdata_vld: got %h expected %h", rdata_vld, m_rd_pipe[2]);
            err_cnt++;
         end
         if (m_rd_pipe[2]) begin
            chk_cnt++;
            assert (rdata === m_rd_exp) else begin
               $display("CHECK FAILED rdata: got %h expected %h", rdata, m_rd_exp);
               err_cnt++;
            end
         end
      end
   end

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   function automatic logic [31:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r;
   endfunction

   function automatic logic [inq_pkg::DATA_W-1:0] rand_entry();
      logic [127:0] r;
      r = {rand_word(), rand_word(), rand_word(), rand_word()};
      return r[inq_pkg::DATA_W-1:0];
   endfunction

   task automatic clear_inputs();
      push         = 1'b0;
      push_data    = '0;
      upd          = 1'b0;
      upd_idx      = '0;
      upd_word_wen = '0;
      upd_data     = '0;
      pop          = 1'b0;
      peek         = 1'b0;
      peek_idx     = '0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge rclk);
         clear_inputs();
      end
   endtask

   task automatic push_entry(input logic [inq_pkg::DATA_W-1:0] data);
      @(negedge rclk);
      clear_inputs();
      push      = 1'b1;
      push_data = data;
   endtask

   task automatic update_entry(input logic [inq_pkg::ADR_W-1:0] idx,
                               input logic [inq_pkg::LANES-1:0] wen,
                               input logic [inq_pkg::DATA_W-1:0] data);
      @(negedge rclk);
      clear_inputs();
      upd          = 1'b1;
      upd_idx      = idx;
      upd_word_wen = wen;
      upd_data     = data;
   endtask

   task automatic pop_entry();
      @(negedge rclk);
      clear_inputs();
      pop = 1'b1;
   endtask

   task automatic peek_entry(input logic [inq_pkg::ADR_W-1:0] idx);
      @(negedge rclk);
      clear_inputs();
      peek     = 1'b1;
      peek_idx = idx;
   endtask

   task automatic report_test(input string name);
      // let the checks of the last cycle land first
      @(posedge rclk);
      test_cnt++;
      if (err_cnt == test_err_base) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic test_reset();
      idle(2);
      // read data comes out of reset cleared
      chk_cnt++;
      assert (rdata === '0) else begin
         $display("CHECK FAILED rdata: got %h expected %h", rdata, 0);
         err_cnt++;
      end
      // nothing queued, so no read may come back
      pop_entry();
      idle(4);
      report_test("reset and empty pop");
   endtask

   task automatic test_fifo_order();
      for (int n = 0; n < N_ORDER; n++) push_entry(rand_entry());
      for (int n = 0; n < N_ORDER; n++) pop_entry();
      idle(4);
      report_test("fifo order");
   endtask

   task automatic test_full();
      for (int n = 0; n < inq_pkg::DEPTH; n++) push_entry(rand_entry());
      // no room left, this entry is lost
      push_entry(rand_entry());
      for (int n = 0; n < inq_pkg::DEPTH; n++) pop_entry();
      idle(4);
      report_test("full and dropped push");
   endtask

   task automatic test_lane_update();
      logic [31:0] w;
      for (int n = 0; n < N_UPD_FILL; n++) push_entry(rand_entry());
      // offsets span 0..31, so about half fall past the count
      for (int n = 0; n < N_UPD; n++) begin
         w = rand_word();
         update_entry(w[4:0], w[8:5], rand_entry());
      end
      update_entry(inq_pkg::ADR_W'(N_UPD_FILL), 4'hf, rand_entry());
      for (int n = 0; n < N_UPD_FILL; n++) pop_entry();
      idle(4);
      report_test("lane updates");
   endtask

   task automatic test_peek();
      logic [31:0] w;
      for (int n = 0; n < N_PK_FILL; n++) push_entry(rand_entry());
      for (int n = 0; n < N_PEEK; n++) begin
         w = rand_word();
         peek_entry({1'b0, w[3:0]});
      end
      // pop and peek together
      @(negedge rclk);
      clear_inputs();
      pop      = 1'b1;
      peek     = 1'b1;
      peek_idx = 5'd3;
      for (int n = 0; n < N_PK_FILL - 1; n++) pop_entry();
      idle(4);
      report_test("peek");
   endtask

   task automatic test_write_priority();
      logic [31:0] w;
      push_entry(rand_entry());
      push_entry(rand_entry());
      // update on a queued entry beside a push goes nowhere
      @(negedge rclk);
      clear_inputs();
      push         = 1'b1;
      push_data    = rand_entry();
      upd          = 1'b1;
      upd_idx      = 5'd1;
      upd_word_wen = '1;
      upd_data     = rand_entry();
      // rewrite the head, then pop it on the next cycle
      w = rand_word();
      update_entry('0, w[3:0] | 4'b0001, rand_entry());
      pop_entry();
      pop_entry();
      pop_entry();
      // single entry pushed and popped right behind it
      push_entry(rand_entry());
      pop_entry();
      idle(4);
      report_test("write priority and bypass");
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////

   initial begin
      clear_inputs();
      reset_l = 1'b1;
      repeat (RESET_CYC) @(posedge rclk);
      @(negedge rclk);
      reset_l = 1'b0;
      test_reset();
      test_fifo_order();
      test_full();
      test_lane_update();
      test_peek();
      test_write_priority();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule
